// File: Bender.yml
package:
  name: msx_slots

sources:
  - source/msx_mem_pkg.sv
  - source/msx_cpu_pkg.sv
  - source/cpu_bus_if.sv
  - source/subslot_regs.sv
  - source/slot_layout_table.sv
  - source/msx2_ram_mapper.sv
  - source/slot_address_decode.sv
  - source/msx_slots_top.sv
  - target: test
    files:
      - verif/msx_slots_tb.sv

// File: source/cpu_bus_if.sv
`timescale 1ns/100ps

// z80 bus as seen by the slot logic
// strobes are plain levels, active high
interface cpu_bus_if;

   msx_cpu_pkg::cpu_addr_t addr;
   // data driven by the cpu
   msx_cpu_pkg::cpu_data_t dout;
   logic                   wr;
   logic                   rd;
   logic                   mreq;
   logic                   iorq;
   // opcode fetch, also set on interrupt acknowledge
   logic                   m1;

   // cpu side
   modport master (
      output addr, dout, wr, rd, mreq, iorq, m1
   );

   // decoding blocks only look
   modport slave (
      input addr, dout, wr, rd, mreq, iorq, m1
   );

endinterface

// File: source/msx2_ram_mapper.sv
`timescale 1ns/100ps

module msx2_ram_mapper (
   input  logic                   clk,
   input  logic                   reset,
   cpu_bus_if.slave               bus,
   input  logic [7:0]             block_count,
   output logic [21:0]            seg_addr,
   output logic                   io_oe,
   output msx_cpu_pkg::cpu_data_t io_dout
);

   // segment per cpu page, index = port low bits
   msx_cpu_pkg::cpu_data_t [3:0] seg_reg;

   msx_cpu_pkg::cpu_data_t seg_mask;
   logic                   port_hit;
   logic [1:0]             port_page;
   logic [1:0]             page;

   // FC..FF, only the low address byte is decoded
   assign port_hit  = bus.iorq &&
                      (bus.addr[7:2] == msx_cpu_pkg::MAPPER_PORT_BASE[7:2]);
   assign port_page = bus.addr[1:0];
   assign page      = bus.addr[15:14];

   // block count is a power of two
   // zero wraps to a full 256 segment mask
   assign seg_mask = block_count - 8'd1;

   // msx2 bios layout after reset
   // page 0 seg 3 down to page 3 seg 0
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         seg_reg <= {8'd0, 8'd1, 8'd2, 8'd3};
      end else if (port_hit && bus.wr && !bus.m1) begin
         seg_reg[port_page] <= bus.dout;
      end
   end

   // unused upper bits read as ones
   assign io_oe   = port_hit && bus.rd;
   assign io_dout = seg_reg[port_page] | ~seg_mask;

   // segment on top of the in-page offset
   assign seg_addr = {seg_reg[page] & seg_mask,
                      bus.addr[msx_cpu_pkg::PAGE_BITS-1:0]};

endmodule

// File: source/msx_cpu_pkg.sv
package msx_cpu_pkg;

   // z80 address and data
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  cpu_data_t;

   // low address bits inside a 16 kB page
   localparam int PAGE_BITS = 14;

   // start of page 1, base of the offset mapper
   localparam cpu_addr_t PAGE1_BASE = 16'h4000;

   // subslot register of an expanded slot
   // reads back inverted
   localparam cpu_addr_t SUBSLOT_REG_ADDR = 16'hFFFF;

   // msx2 memory mapper segment ports
   // FC page 0 up to FF page 3
   localparam logic [7:0] MAPPER_PORT_BASE = 8'hFC;

endpackage

// File: source/msx_mem_pkg.sv
package msx_mem_pkg;

   // how a 16 kB page is turned into a RAM offset
   // none must stay zero so a cleared table decodes as plain RAM
   typedef enum logic [2:0] {
      MAPPER_NONE   = 3'd0,
      MAPPER_LINEAR = 3'd1,
      MAPPER_OFFSET = 3'd2,
      MAPPER_RAM    = 3'd3,
      MAPPER_UNUSED = 3'd4
   } mapper_typ_t;

   // default external RAM address, 128 MB
   typedef logic [26:0] ram_addr_t;

   // slot, subslot, page
   typedef logic [5:0] layout_id_t;

   // one of 16 RAM regions
   typedef logic [3:0] region_id_t;

   // one block table entry, 10 bits
   // first field sits in the top bits
   typedef struct packed {
      // region this page lives in
      region_id_t  ref_ram;
      // 16 kB block inside the region, none kind only
      logic [1:0]  offset_ram;
      mapper_typ_t mapper;
      // spare
      logic        unused;
   } block_t;

   // one RAM region, 44 bits
   typedef struct packed {
      // region base in external RAM
      ram_addr_t   addr;
      // size in 16 kB blocks
      logic [15:0] size;
      // writes are dropped when set
      logic        ro;
   } ram_region_t;

   // table depths
   localparam int LAYOUT_ENTRIES = 64;
   localparam int REGION_ENTRIES = 16;

endpackage

// File: source/msx_slots_top.sv
`timescale 1ns/100ps

module msx_slots_top #(
   parameter int ram_addr_width = 27
) (
   input  logic                       clk,
   input  logic                       reset,
   // z80
   input  logic [15:0]                cpu_addr,
   input  logic [7:0]                 cpu_dout,
   output logic [7:0]                 cpu_din,
   input  logic                       cpu_wr,
   input  logic                       cpu_rd,
   input  logic                       cpu_mreq,
   input  logic                       cpu_iorq,
   input  logic                       cpu_m1,
   // primary slot and which slots are expanded
   input  logic [1:0]                 active_slot,
   input  logic [3:0]                 slot_expanded,
   // table loading
   input  logic                       cfg_layout_wr,
   input  logic                       cfg_region_wr,
   input  logic [5:0]                 cfg_index,
   input  logic [43:0]                cfg_data,
   // external RAM
   output logic [ram_addr_width-1:0]  ram_addr,
   output logic [7:0]                 ram_din,
   input  logic [7:0]                 ram_dout,
   output logic                       ram_rnw,
   output logic                       ram_ce
);

   cpu_bus_if bus ();

   msx_mem_pkg::layout_id_t  layout_id;
   msx_mem_pkg::block_t      entry;
   msx_mem_pkg::ram_region_t region;
   msx_cpu_pkg::cpu_data_t   io_dout;
   msx_cpu_pkg::cpu_data_t   sub_dout;
   logic [21:0]              seg_addr;
   logic [7:0]               block_count;
   logic [1:0]               cur_subslot;
   logic                     io_oe;
   logic                     sub_oe;

   // cpu side of the bus
   assign bus.addr = cpu_addr;
   assign bus.dout = cpu_dout;
   assign bus.wr   = cpu_wr;
   assign bus.rd   = cpu_rd;
   assign bus.mreq = cpu_mreq;
   assign bus.iorq = cpu_iorq;
   assign bus.m1   = cpu_m1;

   subslot_regs u_subslot_regs (
      .clk(clk), .reset(reset), .bus(bus.slave),
      .active_slot(active_slot), .slot_expanded(slot_expanded),
      .cur_subslot(cur_subslot), .sub_oe(sub_oe), .sub_dout(sub_dout)
   );

   slot_layout_table #(.ram_addr_width(ram_addr_width)) u_slot_layout_table (
      .clk(clk), .reset(reset),
      .cfg_layout_wr(cfg_layout_wr), .cfg_region_wr(cfg_region_wr),
      .cfg_index(cfg_index), .cfg_data(cfg_data),
      .layout_id(layout_id), .entry(entry), .region(region)
   );

   msx2_ram_mapper u_msx2_ram_mapper (
      .clk(clk), .reset(reset), .bus(bus.slave), .block_count(block_count),
      .seg_addr(seg_addr), .io_oe(io_oe), .io_dout(io_dout)
   );

   slot_address_decode #(.ram_addr_width(ram_addr_width)) u_slot_address_decode (
      .bus(bus.slave), .active_slot(active_slot), .cur_subslot(cur_subslot),
      .entry(entry), .region(region), .seg_addr(seg_addr),
      .io_oe(io_oe), .io_dout(io_dout), .sub_oe(sub_oe), .sub_dout(sub_dout),
      .ram_dout(ram_dout), .layout_id(layout_id), .block_count(block_count),
      .ram_addr(ram_addr), .ram_din(ram_din), .ram_rnw(ram_rnw),
      .ram_ce(ram_ce), .cpu_din(cpu_din)
   );

endmodule

// File: source/slot_address_decode.sv
`timescale 1ns/100ps

module slot_address_decode #(
   parameter int ram_addr_width = $bits(msx_mem_pkg::ram_addr_t)
) (
   cpu_bus_if.slave                   bus,
   input  logic [1:0]                 active_slot,
   input  logic [1:0]                 cur_subslot,
   input  msx_mem_pkg::block_t        entry,
   input  msx_mem_pkg::ram_region_t   region,
   input  logic [21:0]                seg_addr,
   input  logic                       io_oe,
   input  msx_cpu_pkg::cpu_data_t     io_dout,
   input  logic                       sub_oe,
   input  msx_cpu_pkg::cpu_data_t     sub_dout,
   input  msx_cpu_pkg::cpu_data_t     ram_dout,
   output msx_mem_pkg::layout_id_t    layout_id,
   output logic [7:0]                 block_count,
   output logic [ram_addr_width-1:0]  ram_addr,
   output msx_cpu_pkg::cpu_data_t     ram_din,
   output logic                       ram_rnw,
   output logic                       ram_ce,
   output msx_cpu_pkg::cpu_data_t     cpu_din
);

   typedef logic [ram_addr_width-1:0] addr_t;

   addr_t none_addr;
   addr_t linear_addr;
   addr_t offset_addr;
   addr_t mapper_addr;
   addr_t region_bytes;

   // table index for this access
   assign layout_id = {active_slot, cur_subslot, bus.addr[15:14]};

   // segment count for the msx2 mapper
   assign block_count = region.size[7:0];

   // region size in bytes
   assign region_bytes = addr_t'(region.size) << msx_cpu_pkg::PAGE_BITS;

   // none, 16 kB page picked by offset_ram
   assign none_addr = addr_t'(bus.addr[msx_cpu_pkg::PAGE_BITS-1:0]) +
                      (addr_t'(entry.offset_ram) << msx_cpu_pkg::PAGE_BITS);

   // linear, full cpu address wrapped on the region size
   assign linear_addr = addr_t'(bus.addr) & (region_bytes - addr_t'(1));

   // offset, page 1 maps to the region start
   assign offset_addr = addr_t'(bus.addr) - addr_t'(msx_cpu_pkg::PAGE1_BASE);

   always_comb begin
      case (entry.mapper)
         msx_mem_pkg::MAPPER_NONE:   mapper_addr = none_addr;
         msx_mem_pkg::MAPPER_LINEAR: mapper_addr = linear_addr;
         msx_mem_pkg::MAPPER_OFFSET: mapper_addr = offset_addr;
         msx_mem_pkg::MAPPER_RAM:    mapper_addr = addr_t'(seg_addr);
         // unused points at the region base
         default:                    mapper_addr = '0;
      endcase
   end

   assign ram_addr = addr_t'(region.addr) + mapper_addr;

   // read only regions drop writes
   assign ram_ce  = bus.mreq && (bus.rd || (bus.wr && !region.ro));
   assign ram_rnw = bus.rd;
   assign ram_din = bus.dout;

   // mapper ports first, then FFFF, then memory
   always_comb begin
      if (io_oe) begin
         cpu_din = io_dout;
      end else if (sub_oe) begin
         cpu_din = sub_dout;
      end else if (entry.mapper == msx_mem_pkg::MAPPER_UNUSED) begin
         // open bus
         cpu_din = 8'hFF;
      end else begin
         cpu_din = ram_dout;
      end
   end

endmodule

// File: source/slot_layout_table.sv
`timescale 1ns/100ps

module slot_layout_table #(
   parameter int ram_addr_width = $bits(msx_mem_pkg::ram_addr_t)
) (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic                                          cfg_layout_wr,
   input  logic                                          cfg_region_wr,
   input  logic [5:0]                                    cfg_index,
   input  logic [$bits(msx_mem_pkg::ram_region_t)-1:0]   cfg_data,
   input  msx_mem_pkg::layout_id_t                       layout_id,
   output msx_mem_pkg::block_t                           entry,
   output msx_mem_pkg::ram_region_t                      region
);

   // region bases are clipped to the RAM actually fitted
   localparam msx_mem_pkg::ram_addr_t base_mask =
      msx_mem_pkg::ram_addr_t'({ram_addr_width{1'b1}});

   // block table, indexed by slot, subslot, page
   msx_mem_pkg::block_t [msx_mem_pkg::LAYOUT_ENTRIES-1:0] blocks;

   // region table
   msx_mem_pkg::ram_region_t [msx_mem_pkg::REGION_ENTRIES-1:0] regions;

   msx_mem_pkg::ram_region_t new_region;
   msx_mem_pkg::region_id_t  cfg_region_id;
   msx_mem_pkg::region_id_t  region_id;

   // only the low index bits address a region
   assign cfg_region_id = cfg_index[$bits(msx_mem_pkg::region_id_t)-1:0];

   always_comb begin
      new_region      = msx_mem_pkg::ram_region_t'(cfg_data);
      new_region.addr = new_region.addr & base_mask;
   end

   // host side loading
   // cleared table reads as none kind on region 0
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         blocks  <= '0;
         regions <= '0;
      end else begin
         if (cfg_layout_wr) begin
            blocks[cfg_index] <=
               msx_mem_pkg::block_t'(cfg_data[$bits(msx_mem_pkg::block_t)-1:0]);
         end
         if (cfg_region_wr) begin
            regions[cfg_region_id] <= new_region;
         end
      end
   end

   // lookup chain, entry first then its region
   assign entry     = blocks[layout_id];
   assign region_id = entry.ref_ram;
   assign region    = regions[region_id];

   // host loads one table at a time
   cfg_wr_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      !(cfg_layout_wr && cfg_region_wr)
   ) else $error("layout and region written in the same cycle");

endmodule

// File: source/subslot_regs.sv
`timescale 1ns/100ps

module subslot_regs (
   input  logic                   clk,
   input  logic                   reset,
   cpu_bus_if.slave               bus,
   input  logic [1:0]             active_slot,
   input  logic [3:0]             slot_expanded,
   output logic [1:0]             cur_subslot,
   output logic                   sub_oe,
   output msx_cpu_pkg::cpu_data_t sub_dout
);

   // one register per primary slot
   // two bits per page, page 0 in bits 1:0
   msx_cpu_pkg::cpu_data_t [3:0] sub_reg;

   logic       expanded;
   logic       reg_hit;
   logic [1:0] page;

   assign expanded = slot_expanded[active_slot];
   assign page     = bus.addr[15:14];

   // memory cycle on FFFF of an expanded slot
   assign reg_hit = bus.mreq && expanded &&
                    (bus.addr == msx_cpu_pkg::SUBSLOT_REG_ADDR);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         sub_reg <= '0;
      end else if (reg_hit && bus.wr) begin
         sub_reg[active_slot] <= bus.dout;
      end
   end

   // subslot used by the current page
   // plain slots always look at subslot 0
   always_comb begin
      if (expanded) begin
         cur_subslot = sub_reg[active_slot][{page, 1'b0} +: 2];
      end else begin
         cur_subslot = 2'b00;
      end
   end

   // readback is inverted on real hardware
   assign sub_oe   = reg_hit && bus.rd;
   assign sub_dout = ~sub_reg[active_slot];

   // the cpu never reads and writes in one cycle
   // the table, mapper and decode all rely on this
   rd_wr_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      !(bus.rd && bus.wr)
   ) else $error("cpu rd and wr active together");

endmodule

// File: src.f
source/msx_mem_pkg.sv
source/msx_cpu_pkg.sv
source/cpu_bus_if.sv
source/subslot_regs.sv
source/slot_layout_table.sv
source/msx2_ram_mapper.sv
source/slot_address_decode.sv
source/msx_slots_top.sv
verif/msx_slots_tb.sv

// File: verif/msx_slots_tb.sv
`timescale 1ns/100ps

module msx_slots_tb;

   localparam int RESET_CYCLES = 8;
   localparam int N_CFG        = 21;
   localparam int N_TESTS      = 29;
   // reset, table load and accesses plus slack
   localparam int WATCHDOG_NS  = (RESET_CYCLES + N_CFG + N_TESTS + 20) * 10;

   typedef enum logic [2:0] {OP_IDLE, OP_MRD, OP_MWR, OP_IORD, OP_IOWR} op_t;

   // one cpu cycle of the stimulus table
   // rnd takes lcg write data instead of the fixed byte
   typedef struct packed {
      op_t         op;
      logic [1:0]  slot;
      logic [15:0] addr;
      logic        rnd;
      logic [7:0]  data;
   } access_t;

   logic        clk;
   logic        reset;
   logic [15:0] cpu_addr;
   logic [7:0]  cpu_dout;
   logic [7:0]  cpu_din;
   logic        cpu_wr;
   logic        cpu_rd;
   logic        cpu_mreq;
   logic        cpu_iorq;
   logic        cpu_m1;
   logic [1:0]  active_slot;
   logic [3:0]  slot_expanded;
   logic        cfg_layout_wr;
   logic        cfg_region_wr;
   logic [5:0]  cfg_index;
   logic [43:0] cfg_data;
   logic [26:0] ram_addr;
   logic [7:0]  ram_din;
   logic [7:0]  ram_dout;
   logic        ram_rnw;
   logic        ram_ce;

   // reference model state
   msx_mem_pkg::block_t      m_blk [64];
   msx_mem_pkg::ram_region_t m_rgn [16];
   logic [7:0]               m_sub [4];
   logic [7:0]               m_seg [4];

   access_t     tests [N_TESTS];
   logic [31:0] rng;
   int          checks;
   int          errors;

   msx_slots_top #(.ram_addr_width(27)) UUT (
      .clk(clk), .reset(reset),
      .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_din(cpu_din),
      .cpu_wr(cpu_wr), .cpu_rd(cpu_rd), .cpu_mreq(cpu_mreq),
      .cpu_iorq(cpu_iorq), .cpu_m1(cpu_m1),
      .active_slot(active_slot), .slot_expanded(slot_expanded),
      .cfg_layout_wr(cfg_layout_wr), .cfg_region_wr(cfg_region_wr),
      .cfg_index(cfg_index), .cfg_data(cfg_data),
      .ram_addr(ram_addr), .ram_din(ram_din), .ram_dout(ram_dout),
      .ram_rnw(ram_rnw), .ram_ce(ram_ce)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input int idx,
                              input logic [31:0] got, input logic [31:0] want);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("[FAIL] %s entry %0d: got %h expected %h", name, idx, got, want);
      end
   endtask

   // one table write per cycle, model follows
   task automatic cfg_write(input logic to_region, input logic [5:0] idx,
                            input logic [43:0] data);
      @(posedge clk);
      #1;
      cfg_layout_wr = !to_region;
      cfg_region_wr = to_region;
      cfg_index     = idx;
      cfg_data      = data;
      if (to_region) begin
         m_rgn[idx[3:0]] = data;
      end else begin
         m_blk[idx] = data[9:0];
      end
   endtask

   // regions: base, size in 16 kB blocks, read only
   // slot 3 expanded, subslot n uses region n
   task automatic load_tables();
      cfg_write(1'b1, 6'd0, {27'h0000000, 16'd4, 1'b0});
      cfg_write(1'b1, 6'd1, {27'h0100000, 16'd8, 1'b0});
      cfg_write(1'b1, 6'd2, {27'h0200000, 16'd2, 1'b1});
      cfg_write(1'b1, 6'd3, {27'h0400000, 16'd16, 1'b0});
      for (int p = 0; p < 4; p++) begin
         cfg_write(1'b0, {2'd3, 2'd0, 2'(p)}, {4'd0, 2'(p), msx_mem_pkg::MAPPER_NONE, 1'b0});
         cfg_write(1'b0, {2'd3, 2'd1, 2'(p)}, {4'd1, 2'd0, msx_mem_pkg::MAPPER_LINEAR, 1'b0});
         cfg_write(1'b0, {2'd3, 2'd2, 2'(p)}, {4'd2, 2'd0, msx_mem_pkg::MAPPER_OFFSET, 1'b0});
         cfg_write(1'b0, {2'd3, 2'd3, 2'(p)}, {4'd3, 2'd0, msx_mem_pkg::MAPPER_RAM, 1'b0});
      end
      // slot 1 page 2 left open
      cfg_write(1'b0, {2'd1, 2'd0, 2'd2}, {4'd0, 2'd0, msx_mem_pkg::MAPPER_UNUSED, 1'b0});
   endtask

   // op, slot, address, lcg data, fixed data
   task automatic fill_access_table();
      tests[0]  = '{OP_IDLE, 2'd0, 16'h0000, 1'b0, 8'h00};
      tests[1]  = '{OP_MRD,  2'd3, 16'hFFFF, 1'b0, 8'h00};
      tests[2]  = '{OP_MWR,  2'd3, 16'hFFFF, 1'b0, 8'hE4};
      tests[3]  = '{OP_MRD,  2'd3, 16'hFFFF, 1'b0, 8'h00};
      tests[4]  = '{OP_MRD,  2'd3, 16'h0100, 1'b0, 8'h00};
      tests[5]  = '{OP_MRD,  2'd3, 16'h4567, 1'b0, 8'h00};
      tests[6]  = '{OP_MWR,  2'd3, 16'h89AB, 1'b1, 8'h00};
      tests[7]  = '{OP_MRD,  2'd3, 16'h89AB, 1'b0, 8'h00};
      tests[8]  = '{OP_MRD,  2'd0, 16'hFFFF, 1'b0, 8'h00};
      tests[9]  = '{OP_MWR,  2'd0, 16'hFFFF, 1'b1, 8'h00};
      tests[10] = '{OP_MRD,  2'd3, 16'hFFFF, 1'b0, 8'h00};
      tests[11] = '{OP_MWR,  2'd3, 16'hFFFF, 1'b0, 8'h55};
      tests[12] = '{OP_MRD,  2'd3, 16'hC000, 1'b0, 8'h00};
      tests[13] = '{OP_MWR,  2'd3, 16'h2345, 1'b1, 8'h00};
      tests[14] = '{OP_MRD,  2'd1, 16'h8000, 1'b0, 8'h00};
      tests[15] = '{OP_MRD,  2'd1, 16'h0010, 1'b0, 8'h00};
      tests[16] = '{OP_MWR,  2'd3, 16'hFFFF, 1'b0, 8'hAA};
      tests[17] = '{OP_MRD,  2'd3, 16'h7FFE, 1'b0, 8'h00};
      tests[18] = '{OP_MWR,  2'd3, 16'h7FFE, 1'b1, 8'h00};
      tests[19] = '{OP_MWR,  2'd3, 16'hFFFF, 1'b0, 8'hFF};
      tests[20] = '{OP_IORD, 2'd3, 16'h00FE, 1'b0, 8'h00};
      tests[21] = '{OP_IOWR, 2'd3, 16'h00FC, 1'b0, 8'h05};
      tests[22] = '{OP_IOWR, 2'd3, 16'h00FD, 1'b0, 8'h1A};
      tests[23] = '{OP_IORD, 2'd3, 16'h00FD, 1'b0, 8'h00};
      tests[24] = '{OP_MRD,  2'd3, 16'h1234, 1'b0, 8'h00};
      tests[25] = '{OP_MWR,  2'd3, 16'h5678, 1'b1, 8'h00};
      tests[26] = '{OP_MRD,  2'd3, 16'hBFFF, 1'b0, 8'h00};
      tests[27] = '{OP_IORD, 2'd1, 16'h00FF, 1'b0, 8'h00};
      tests[28] = '{OP_MRD,  2'd3, 16'hFFFF, 1'b0, 8'h00};
   endtask

   task automatic drive_access(input access_t a, input logic [7:0] wdata,
                               input logic [7:0] rdata);
      active_slot = a.slot;
      cpu_addr    = a.addr;
      cpu_dout    = wdata;
      cpu_rd      = (a.op == OP_MRD) || (a.op == OP_IORD);
      cpu_wr      = (a.op == OP_MWR) || (a.op == OP_IOWR);
      cpu_mreq    = (a.op == OP_MRD) || (a.op == OP_MWR);
      cpu_iorq    = (a.op == OP_IORD) || (a.op == OP_IOWR);
      ram_dout    = rdata;
   endtask

   // expected RAM address, chip enable and read data
   task automatic predict(input access_t a, input logic [7:0] rdata,
                          output logic [26:0] e_addr, output logic e_ce,
                          output logic [7:0] e_din);
      logic [1:0]               page;
      logic [1:0]               sub;
      msx_mem_pkg::block_t      blk;
      msx_mem_pkg::ram_region_t rgn;
      logic [26:0]              off;
      logic [7:0]               mask;
      page = a.addr[15:14];
      sub  = slot_expanded[a.slot] ? m_sub[a.slot][2*page +: 2] : 2'd0;
      blk  = m_blk[{a.slot, sub, page}];
      rgn  = m_rgn[blk.ref_ram];
      mask = rgn.size[7:0] - 8'd1;
      case (blk.mapper)
         msx_mem_pkg::MAPPER_NONE:   off = 27'({blk.offset_ram, a.addr[13:0]});
         msx_mem_pkg::MAPPER_LINEAR: off = 27'(a.addr) & ((27'(rgn.size) << 14) - 27'd1);
         msx_mem_pkg::MAPPER_OFFSET: off = 27'(a.addr) - 27'h4000;
         msx_mem_pkg::MAPPER_RAM:    off = 27'({m_seg[page] & mask, a.addr[13:0]});
         default:                    off = '0;
      endcase
      e_addr = rgn.addr + off;
      e_ce   = (a.op == OP_MRD) || (a.op == OP_MWR && !rgn.ro);
      if (a.op == OP_IORD && a.addr[7:2] == 6'h3F) begin
         e_din = m_seg[a.addr[1:0]] | ~mask;
      end else if (a.op == OP_MRD && a.addr == 16'hFFFF && slot_expanded[a.slot]) begin
         e_din = ~m_sub[a.slot];
      end else if (blk.mapper == msx_mem_pkg::MAPPER_UNUSED) begin
         e_din = 8'hFF;
      end else begin
         e_din = rdata;
      end
   endtask

   // registers change at the edge after the write
   task automatic update_model(input access_t a, input logic [7:0] wdata);
      if (a.op == OP_MWR && a.addr == 16'hFFFF && slot_expanded[a.slot]) begin
         m_sub[a.slot] = wdata;
      end
      if (a.op == OP_IOWR && a.addr[7:2] == 6'h3F && !cpu_m1) begin
         m_seg[a.addr[1:0]] = wdata;
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the access sequence did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      logic [7:0]  wdata;
      logic [7:0]  rdata;
      logic [26:0] e_addr;
      logic        e_ce;
      logic [7:0]  e_din;
      clk           = 1'b0;
      reset         = 1'b1;
      cpu_m1        = 1'b0;
      slot_expanded = 4'b1000;
      cfg_layout_wr = 1'b0;
      cfg_region_wr = 1'b0;
      cfg_index     = '0;
      cfg_data      = '0;
      drive_access('{OP_IDLE, 2'd0, 16'h0000, 1'b0, 8'h00}, 8'h00, 8'h00);
      rng    = 32'hee5c3f40;
      checks = 0;
      errors = 0;
      // model reset state, segments 3 2 1 0
      foreach (m_blk[k]) m_blk[k] = '0;
      foreach (m_rgn[k]) m_rgn[k] = '0;
      for (int k = 0; k < 4; k++) begin
         m_sub[k] = 8'h00;
         m_seg[k] = 8'(3 - k);
      end
      fill_access_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      load_tables();
      @(posedge clk);
      #1;
      cfg_layout_wr = 1'b0;
      cfg_region_wr = 1'b0;
      for (int i = 0; i < N_TESTS; i++) begin
         @(posedge clk);
         #1;
         rng   = lcg_next(rng);
         wdata = tests[i].rnd ? rng[23:16] : tests[i].data;
         rng   = lcg_next(rng);
         rdata = rng[23:16];
         drive_access(tests[i], wdata, rdata);
         predict(tests[i], rdata, e_addr, e_ce, e_din);
         // sample just ahead of the next edge
         #8;
         check_value("ram_ce", i, ram_ce, e_ce);
         if (cpu_mreq) begin
            check_value("ram_addr", i, ram_addr, e_addr);
            check_value("ram_rnw", i, ram_rnw, cpu_rd);
            check_value("ram_din", i, ram_din, wdata);
         end
         if (cpu_rd) begin
            check_value("cpu_din", i, cpu_din, e_din);
         end
         update_model(tests[i], wdata);
      end
      @(posedge clk);
      #1;
      drive_access('{OP_IDLE, 2'd0, 16'h0000, 1'b0, 8'h00}, 8'h00, 8'h00);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
